// ==== sim/div_unit_input.txt ====
// Columns op rs1 rs2 expected in hex
// Op codes 0 DIV 1 DIVU 2 REM 3 REMU
1 00000007 00000002 00000003
3 00000007 00000002 00000001
1 12345678 12345678 00000001
3 12345678 12345678 00000000
1 ffffffff 00010000 0000ffff
3 ffffffff 00010000 0000ffff
1 80000000 00000003 2aaaaaaa
3 80000000 00000003 00000002
1 80000000 00000001 80000000
0 fffffff9 00000002 fffffffd
0 00000007 fffffffe fffffffd
0 fffffff9 fffffffe 00000003
2 fffffff9 00000002 ffffffff
2 00000007 fffffffe 00000001
2 fffffff9 fffffffe ffffffff
0 00001234 00000000 ffffffff
1 00001234 00000000 ffffffff
2 80001234 00000000 80001234
3 00001234 00000000 00001234
0 80000000 ffffffff 80000000
2 80000000 ffffffff 00000000
1 00000005 00000009 00000000
3 00000001 80000000 00000001
2 fffffffb 00000009 fffffffb

// ==== flist.f ====
common/div_pkg.sv
hw/div/div_clz.sv
hw/div/div_operand_prep.sv
hw/div/div_core.sv
hw/div/div_result_fix.sv
hw/div_unit.sv
sim/div_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the divide unit testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module div_unit_tb -Mdir obj_dir -f flist.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

sim_output=$(./obj_dir/Vdiv_unit_tb)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -q "^Verification passed$"; then
    exit 0
else
    echo "Pass message not found in the simulation output"
    exit 1
fi

// ==== sim/div_unit_tb.sv ====
//////////////////////////////
// Testbench for the divide unit
// Vector reader, request driver,
// busy and result checks, watchdog
//////////////////////////////

`timescale 1ns/100ps

module div_unit_tb;

    localparam int    XLEN         = div_pkg::XLEN;
    localparam int    CLK_PERIOD   = 40;
    localparam int    DRIVE_DELAY  = 2;    // After the rising edge
    localparam int    RESET_CYCLES = 10;
    localparam int    MAX_VEC      = 64;
    localparam int    MAX_LATENCY  = 20;   // Accept to result_valid
    localparam int    VEC_CYCLES   = 30;   // Watchdog budget per vector
    localparam string VEC_FILE     = "sim/div_unit_input.txt";

    logic                  clk;
    logic                  rst;
    div_pkg::div_request_t req;
    logic                  req_valid;
    logic                  busy;
    logic [XLEN-1:0]       result;
    logic                  result_valid;

    // Vector storage
    logic [1:0]      vec_op  [MAX_VEC];
    logic [XLEN-1:0] vec_rs1 [MAX_VEC];
    logic [XLEN-1:0] vec_rs2 [MAX_VEC];
    logic [XLEN-1:0] vec_exp [MAX_VEC];

    int   num_vec     = 0;
    int   error_count = 0;
    int   pulse_count = 0;    // result_valid pulses seen
    logic load_done   = 1'b0;

    div_unit #(.XLEN(XLEN)) dut (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .req_valid    (req_valid),
        .busy         (busy),
        .result       (result),
        .result_valid (result_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Outputs change on the rising edge, count at the falling one
    always @(negedge clk) begin
        if (result_valid) begin
            pulse_count++;
        end
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////
    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // One vector per line, lines that do not scan are skipped
    task automatic load_vectors();
        int          fd;
        int          code;
        string       line;
        logic [31:0] op_tmp;
        logic [31:0] rs1_tmp;
        logic [31:0] rs2_tmp;
        logic [31:0] exp_tmp;
        num_vec = 0;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the vector file %s", VEC_FILE);
        end else begin
            while (!$feof(fd) && num_vec < MAX_VEC) begin
                code = $fgets(line, fd);
                if (code != 0 &&
                    $sscanf(line, "%h %h %h %h", op_tmp, rs1_tmp, rs2_tmp, exp_tmp) == 4) begin
                    vec_op[num_vec]  = op_tmp[1:0];
                    vec_rs1[num_vec] = rs1_tmp;
                    vec_rs2[num_vec] = rs2_tmp;
                    vec_exp[num_vec] = exp_tmp;
                    num_vec++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic drive_request(input logic [1:0] op, input logic [XLEN-1:0] rs1,
                                 input logic [XLEN-1:0] rs2);
        req.op    = div_pkg::div_op_t'(op);
        req.rs1   = rs1;
        req.rs2   = rs2;
        req_valid = 1'b1;
    endtask

    //////////////////////////////
    // One request and its result
    //////////////////////////////
    task automatic run_vector(input int idx);
        div_pkg::div_op_t op_e;
        string            name;
        int               cycles;
        int               gap;
        logic             got;
        op_e   = div_pkg::div_op_t'(vec_op[idx]);
        name   = $sformatf("vector %0d %s", idx, op_e.name());
        got    = 1'b0;
        cycles = 0;
        @(posedge clk);
        #DRIVE_DELAY;
        drive_request(vec_op[idx], vec_rs1[idx], vec_rs2[idx]);
        @(posedge clk);  // Accepting edge
        #DRIVE_DELAY;
        if (idx % 2 == 1) begin
            // Decoy while busy, must be dropped
            drive_request(vec_op[idx], vec_rs1[idx] ^ 32'h5a5a5a5a, vec_rs2[idx] + 32'd1);
        end else begin
            req_valid = 1'b0;
        end
        while (!got && cycles < MAX_LATENCY) begin
            @(negedge clk);
            cycles++;
            check_value($sformatf("%s busy", name), 32'd1, 32'(busy));
            if (result_valid) begin
                got = 1'b1;
                check_value($sformatf("%s result", name), vec_exp[idx], result);
            end else begin
                @(posedge clk);
                #DRIVE_DELAY;
                req_valid = 1'b0;
            end
        end
        if (!got) begin
            error_count++;
            $display("%s gave no result_valid within %0d cycles", name, MAX_LATENCY);
        end
        // Busy low in the cycle after the result
        @(posedge clk);
        #DRIVE_DELAY;
        @(negedge clk);
        check_value($sformatf("%s busy after result", name), 32'd0, 32'(busy));
        gap = $urandom % 4;  // Idle cycles 0 to 3
        repeat (gap) @(posedge clk);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        int seed_unused;
        rst         = 1'b1;
        req_valid   = 1'b0;
        req         = '0;
        seed_unused = $urandom(32'h3521e49c);
        load_vectors();
        load_done = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        if (num_vec == 0) begin
            error_count++;
            $display("No vectors were read from %s", VEC_FILE);
        end
        for (int i = 0; i < num_vec; i++) begin
            run_vector(i);
        end
        repeat (4) @(posedge clk);  // Room for a stray pulse
        check_value("result_valid pulse count", num_vec, pulse_count);
        $display("Run finished with %0d vectors and %0d errors", num_vec, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Budget scales with the vector count
    initial begin
        wait (load_done);
        repeat ((num_vec + 1) * VEC_CYCLES + RESET_CYCLES) @(posedge clk);
        $display("Watchdog timeout, the run took longer than its cycle budget");
        $display("Verification failed");
        $finish;
    end

endmodule

// ==== hw/div_unit.sv ====
//////////////////////////////
// Integer divide unit top
// Prep, core and result stage
// plus the busy level
//////////////////////////////

`timescale 1ns/100ps

module div_unit #(
    parameter int XLEN = div_pkg::XLEN
) (
    input  logic                  clk,
    input  logic                  rst,
    input  div_pkg::div_request_t req,
    input  logic                  req_valid,
    output logic                  busy,
    output logic [XLEN-1:0]       result,
    output logic                  result_valid
);

    logic                   accept;
    logic                   start;
    logic                   done;
    div_pkg::div_operands_t operands;
    div_pkg::div_ctrl_t     ctrl;
    logic [XLEN-1:0]        quotient;
    logic [XLEN-1:0]        remainder;

    //////////////////////////////
    // Request acceptance
    //////////////////////////////
    assign accept = req_valid & ~busy;  // Dropped while busy, no queue

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (accept) begin
            busy <= 1'b1;
        end else if (result_valid) begin
            busy <= 1'b0;
        end
    end

    //////////////////////////////
    // Stages
    //////////////////////////////
    div_operand_prep #(.DIV_WIDTH(XLEN)) prep_i (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .accept   (accept),
        .operands (operands),
        .ctrl     (ctrl),
        .start    (start)
    );

    div_core #(.DIV_WIDTH(XLEN)) core_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .operands  (operands),
        .quotient  (quotient),
        .remainder (remainder),
        .done      (done)
    );

    div_result_fix #(.DIV_WIDTH(XLEN)) fix_i (
        .clk          (clk),
        .rst          (rst),
        .ctrl         (ctrl),
        .quotient     (quotient),
        .remainder    (remainder),
        .done         (done),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

// ==== hw/div/div_result_fix.sv ====
//////////////////////////////
// Result stage
// Sign fix, divide-by-zero rule,
// quotient or remainder pick
//////////////////////////////

`timescale 1ns/100ps

module div_result_fix #(
    parameter int DIV_WIDTH = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  div_pkg::div_ctrl_t   ctrl,
    input  logic [DIV_WIDTH-1:0] quotient,
    input  logic [DIV_WIDTH-1:0] remainder,
    input  logic                 done,
    output logic [DIV_WIDTH-1:0] result,
    output logic                 result_valid
);

    logic                 done_q;  // Core outputs settle one cycle after done
    logic [DIV_WIDTH-1:0] quotient_fixed;
    logic [DIV_WIDTH-1:0] remainder_fixed;
    logic [DIV_WIDTH-1:0] selected;

    //////////////////////////////
    // Correction
    //////////////////////////////
    // Divide by zero gives all ones, negate flag is already off then
    // MIN / -1 comes out as MIN with no special case
    assign quotient_fixed = ctrl.divisor_is_zero ? '1 :
                            ctrl.negate_quotient ? -quotient : quotient;

    // Core already returns the dividend as remainder on zero divisor
    assign remainder_fixed = ctrl.negate_remainder ? -remainder : remainder;

    assign selected = ctrl.is_rem ? remainder_fixed : quotient_fixed;

    //////////////////////////////
    // Output register
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (done_q) begin
            result <= selected;  // Steady until the next completion
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done_q       <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            done_q       <= done;
            result_valid <= done_q;  // Two cycles behind done
        end
    end

endmodule

// ==== hw/div/div_core.sv ====
//////////////////////////////
// Radix-4 unsigned divider core
// Aligns by leading-zero counts
// and terminates early
//////////////////////////////

`timescale 1ns/100ps

module div_core #(
    parameter int DIV_WIDTH = 32
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  div_pkg::div_operands_t operands,
    output logic [DIV_WIDTH-1:0]   quotient,
    output logic [DIV_WIDTH-1:0]   remainder,
    output logic                   done
);

    localparam int CLZ_W = $clog2(DIV_WIDTH);

    logic [CLZ_W-1:0]     delta;           // divisor_clz - dividend_clz
    logic                 delta_neg;       // Divisor larger than dividend
    logic                 abort;
    logic [DIV_WIDTH-1:0] shifted_divisor;
    logic [DIV_WIDTH+1:0] sub_2x_full;
    logic [DIV_WIDTH:0]   sub_1x_full;
    logic [DIV_WIDTH-1:0] sub_2x;
    logic [DIV_WIDTH-1:0] sub_1x;
    logic                 sub_2x_borrow;
    logic                 sub_1x_borrow;
    logic [1:0]           new_bits;        // Two quotient bits per cycle
    logic [CLZ_W-2:0]     cycles_left;
    logic [CLZ_W-2:0]     cycles_left_next;
    logic                 terminate;
    logic                 running;

    //////////////////////////////
    // Alignment
    //////////////////////////////
    assign {delta_neg, delta} = {1'b0, operands.divisor_clz} - {1'b0, operands.dividend_clz};
    assign abort = delta_neg | operands.divisor_is_zero;

    // Shift by delta rounded down to even, then two bits per step
    always_ff @(posedge clk) begin
        if (start) begin
            shifted_divisor <= operands.divisor << {delta[CLZ_W-1:1], 1'b0};
        end else if (running) begin
            shifted_divisor <= {2'b00, shifted_divisor[DIV_WIDTH-1:2]};
        end
    end

    //////////////////////////////
    // Subtract stage
    //////////////////////////////
    // Twice the divisor first, extra top bit catches the borrow
    assign sub_2x_full   = {2'b00, remainder} - {1'b0, shifted_divisor, 1'b0};
    assign sub_2x_borrow = sub_2x_full[DIV_WIDTH+1];
    assign sub_2x        = sub_2x_full[DIV_WIDTH-1:0];

    // Then once more on whichever value survived
    assign sub_1x_full   = {1'b0, (sub_2x_borrow ? remainder : sub_2x)} -
                           {1'b0, shifted_divisor};
    assign sub_1x_borrow = sub_1x_full[DIV_WIDTH];
    assign sub_1x        = sub_1x_full[DIV_WIDTH-1:0];

    assign new_bits = {~sub_2x_borrow, ~sub_1x_borrow};

    always_ff @(posedge clk) begin
        if (start) begin
            quotient <= '0;
        end else if (running) begin
            quotient <= {quotient[DIV_WIDTH-3:0], new_bits};
        end
    end

    // Holds when both new bits are zero
    always_ff @(posedge clk) begin
        if (start) begin
            remainder <= operands.dividend;
        end else if (running && new_bits != 2'b00) begin
            remainder <= sub_1x_borrow ? sub_2x : sub_1x;
        end
    end

    //////////////////////////////
    // Control
    //////////////////////////////
    assign {terminate, cycles_left_next} = {1'b0, cycles_left} - CLZ_W'(1);  // Borrow at zero

    always_ff @(posedge clk) begin
        if (rst) begin
            running     <= 1'b0;
            cycles_left <= '0;
        end else begin
            running     <= (running & ~terminate) | (start & ~abort);
            cycles_left <= running ? cycles_left_next : delta[CLZ_W-1:1];
        end
    end

    // Early exit lands in the start cycle
    assign done = (running & terminate) | (start & abort);

endmodule

// ==== hw/div/div_operand_prep.sv ====
//////////////////////////////
// Operand prep stage
// Request register, magnitudes,
// leading-zero counts, sign flags
// and the core start strobe
//////////////////////////////

`timescale 1ns/100ps

module div_operand_prep #(
    parameter int DIV_WIDTH = 32
) (
    input  logic                   clk,
    input  logic                   rst,
    input  div_pkg::div_request_t  req,
    input  logic                   accept,
    output div_pkg::div_operands_t operands,
    output div_pkg::div_ctrl_t     ctrl,
    output logic                   start
);

    localparam int CLZ_W = $clog2(DIV_WIDTH);

    logic                 is_signed;
    logic                 rs1_neg;
    logic                 rs2_neg;
    logic                 rs2_zero;
    logic [DIV_WIDTH-1:0] rs1_abs;
    logic [DIV_WIDTH-1:0] rs2_abs;
    logic [CLZ_W-1:0]     rs1_clz;
    logic [CLZ_W-1:0]     rs2_clz;

    //////////////////////////////
    // Magnitudes
    //////////////////////////////
    assign is_signed = ~req.op[0];                        // DIV and REM
    assign rs1_neg   = is_signed & req.rs1[DIV_WIDTH-1];
    assign rs2_neg   = is_signed & req.rs2[DIV_WIDTH-1];
    assign rs2_zero  = (req.rs2 == '0);

    // Most negative value maps onto itself, fine as unsigned
    assign rs1_abs = rs1_neg ? -req.rs1 : req.rs1;
    assign rs2_abs = rs2_neg ? -req.rs2 : req.rs2;

    // Counts taken on the magnitudes, ahead of the register
    div_clz #(.WIDTH(DIV_WIDTH)) dividend_clz_i (
        .value (rs1_abs),
        .clz   (rs1_clz)
    );

    div_clz #(.WIDTH(DIV_WIDTH)) divisor_clz_i (
        .value (rs2_abs),
        .clz   (rs2_clz)
    );

    //////////////////////////////
    // Registers
    //////////////////////////////
    // Payload, held until the next accepted request
    always_ff @(posedge clk) begin
        if (accept) begin
            operands.dividend        <= rs1_abs;
            operands.divisor         <= rs2_abs;
            operands.dividend_clz    <= rs1_clz;
            operands.divisor_clz     <= rs2_clz;
            operands.divisor_is_zero <= rs2_zero;

            ctrl.is_rem           <= req.op[1];
            ctrl.negate_quotient  <= (rs1_neg ^ rs2_neg) & ~rs2_zero;  // Zero rule wins
            ctrl.negate_remainder <= rs1_neg;                          // Follows dividend
            ctrl.divisor_is_zero  <= rs2_zero;
        end
    end

    // One-cycle core kick, operands valid alongside
    always_ff @(posedge clk) begin
        if (rst) begin
            start <= 1'b0;
        end else begin
            start <= accept;
        end
    end

endmodule

// ==== hw/div/div_clz.sv ====
//////////////////////////////
// Leading-zero counter
// Priority search from the top bit
//////////////////////////////

`timescale 1ns/100ps

module div_clz #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0]         value,
    output logic [$clog2(WIDTH)-1:0] clz
);

    localparam int OUT_W = $clog2(WIDTH);

    // Zero input reports WIDTH-1, same as a value of 1
    // Keeps a zero dividend from looking smaller than any divisor
    localparam logic [OUT_W-1:0] ZERO_CLZ = OUT_W'(WIDTH - 1);

    //////////////////////////////
    // Search
    //////////////////////////////
    always_comb begin
        logic found;
        found = 1'b0;
        clz   = ZERO_CLZ;  // Default when no bit is set
        for (int i = WIDTH - 1; i >= 0; i--) begin
            // First set bit from the top wins
            if (!found && value[i]) begin
                clz   = OUT_W'(WIDTH - 1 - i);
                found = 1'b1;
            end
        end
    end

endmodule

// ==== common/div_pkg.sv ====
//////////////////////////////
// Integer divide unit package
// Word width, op encoding and the
// structs passed between stages
//////////////////////////////

package div_pkg;

    localparam int XLEN  = 32;
    localparam int CLZ_W = $clog2(XLEN);  // Width of a leading-zero count

    //////////////////////////////
    // Operations
    //////////////////////////////
    // Bit 1 picks the remainder, bit 0 marks the unsigned form
    typedef enum logic [1:0] {
        DIV  = 2'b00,
        DIVU = 2'b01,
        REM  = 2'b10,
        REMU = 2'b11
    } div_op_t;

    // One request as seen at the unit boundary
    typedef struct packed {
        div_op_t         op;
        logic [XLEN-1:0] rs1;  // Dividend
        logic [XLEN-1:0] rs2;  // Divisor
    } div_request_t;

    //////////////////////////////
    // Prep stage to core
    //////////////////////////////
    typedef struct packed {
        logic [XLEN-1:0]  dividend;  // Magnitude
        logic [XLEN-1:0]  divisor;   // Magnitude
        logic [CLZ_W-1:0] dividend_clz;
        logic [CLZ_W-1:0] divisor_clz;
        logic             divisor_is_zero;
    } div_operands_t;

    // Held by prep for the result stage
    typedef struct packed {
        logic is_rem;
        logic negate_quotient;
        logic negate_remainder;
        logic divisor_is_zero;
    } div_ctrl_t;

endpackage
